// ==== design/popeye_defs.svh ====
`ifndef POPEYE_DEFS_SVH
`define POPEYE_DEFS_SVH

// CPU side
`define POPEYE_ADDR_W   16

// Game ROM, 32 KB
`define POPEYE_ROM_AW   15

// Work RAM, 2 KB
`define POPEYE_RAM_AW   11

// Sprite DMA sees the upper 1 KB only
`define POPEYE_DMA_AW   10

// Blank edges before the CPU gets reset
`define POPEYE_WD_LIMIT 16

`endif

// ==== design/bus_pkg.sv ====
package bus_pkg;

`include "popeye_defs.svh"

// Z80 address, scrambled or plain
typedef logic [`POPEYE_ADDR_W-1:0] cpu_addr_t;

typedef logic [7:0] byte_t;

typedef logic [`POPEYE_ROM_AW-1:0] rom_addr_t;
typedef logic [`POPEYE_RAM_AW-1:0] ram_addr_t;
typedef logic [`POPEYE_DMA_AW-1:0] dma_addr_t;

endpackage

// ==== design/board_pkg.sv ====
package board_pkg;

// Device owning the current memory cycle
typedef enum logic [2:0] {
    DEV_NONE,
    DEV_ROM,
    DEV_RAM,
    DEV_TXT,   // Text layer
    DEV_BKG,   // Background layer
    DEV_SEC    // Protection chip
} dev_sel_e;

typedef logic [4:0] joy_t;    // Active low
typedef logic [3:0] dip1_t;

endpackage

// ==== design/addr_unscramble.sv ====
`timescale 1ns/1ps

module addr_unscramble
    import bus_pkg::*;
(
    input  logic      encrypted,
    input  cpu_addr_t cpu_addr,
    input  byte_t     rom_data,
    output cpu_addr_t ad,
    output rom_addr_t rom_addr,
    output byte_t     rom_good
);

always_comb begin
    if (encrypted) begin
        ad[2:0]   = ~cpu_addr[2:0];
        ad[3]     = ~cpu_addr[4];
        ad[4]     = ~cpu_addr[5];
        ad[5]     = ~cpu_addr[9];
        ad[6]     =  cpu_addr[3];
        ad[7]     =  cpu_addr[6];
        ad[8]     =  cpu_addr[7];
        ad[9]     =  cpu_addr[8];
        ad[15:10] =  cpu_addr[15:10];   // Upper bits untouched
        // ROM bytes are stored with their bits swapped
        rom_good  = {rom_data[3], rom_data[4], rom_data[2], rom_data[5],
                     rom_data[1], rom_data[6], rom_data[0], rom_data[7]};
    end else begin
        ad       = cpu_addr;
        rom_good = rom_data;
    end
end

// 32 KB ROM window
assign rom_addr = ad[$bits(rom_addr_t)-1:0];

endmodule

// ==== design/bus_decode.sv ====
`timescale 1ns/1ps

module bus_decode
    import bus_pkg::*;
    import board_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cpu_cen,
    input  logic      mreq_n,
    input  logic      iorq_n,
    input  logic      rd_n,
    input  logic      wr_n,
    input  cpu_addr_t ad,
    input  byte_t     rom_good,
    input  byte_t     ram_q,
    input  byte_t     sec_q,
    input  logic      rom_ok,
    input  logic      coin,
    input  logic      service,
    input  logic      initeo,
    input  logic [1:0] start,
    input  joy_t      joy1,
    input  joy_t      joy2,
    input  dip1_t     dip1,
    output logic      rom_cs,
    output logic      ram_cs,
    output logic      sec_cs,
    output logic      wait_n,
    output logic      mem_wr,
    output logic      csv_l,
    output logic      csb_w_n,
    output logic      dwrbk,
    output byte_t     cpu_din
);

dev_sel_e dev_sel;
byte_t    cab_in;
logic     csv;
logic     csb;
logic     csb_l;
logic     rom_cs_l;

//////////////////////////////
// Memory map
always_comb begin
    dev_sel = DEV_NONE;
    if (!mreq_n) begin
        case (ad[15:13])
            3'b100:  dev_sel = ad[11] ? DEV_RAM : DEV_ROM;  // 8800-8FFF
            3'b101:  dev_sel = DEV_TXT;
            3'b110:  dev_sel = DEV_BKG;   // Nibble planes at C000/D000
            3'b111:  dev_sel = DEV_SEC;   // E000/E001
            default: dev_sel = DEV_ROM;
        endcase
    end
end

assign rom_cs = dev_sel == DEV_ROM;
assign ram_cs = dev_sel == DEV_RAM;
assign sec_cs = dev_sel == DEV_SEC;
assign csv    = dev_sel == DEV_TXT;
assign csb    = dev_sel == DEV_BKG;

//////////////////////////////
// Cabinet ports
always_comb begin
    case (ad[1:0])
        2'd0:    cab_in = {4'hf, dip1};
        2'd1:    cab_in = {coin, service, initeo, 1'b1, start, 2'b11};
        2'd2:    cab_in = {3'b111, joy2};
        default: cab_in = {3'b111, joy1};
    endcase
end

// Read data back to the CPU
always_comb begin
    cpu_din = 8'hff;
    if (!rd_n) begin
        if (!mreq_n && iorq_n) begin
            case (dev_sel)
                DEV_ROM: cpu_din = rom_good;
                DEV_RAM: cpu_din = ram_q;
                DEV_SEC: cpu_din = sec_q;
                default: cpu_din = 8'hff;
            endcase
        end else if (mreq_n && !iorq_n) begin
            cpu_din = cab_in;
        end
    end
end

//////////////////////////////
// Video strobes, one clock late
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        mem_wr  <= 1'b0;
        csv_l   <= 1'b0;
        dwrbk   <= 1'b0;
        csb_w_n <= 1'b1;
        csb_l   <= 1'b0;
    end else begin
        mem_wr  <= ~wr_n & ~mreq_n;
        csv_l   <= csv;
        dwrbk   <= csb & ~wr_n;
        csb_w_n <= ~(csb | csb_l);     // Stretched by one CPU cycle
        if (cpu_cen)
            csb_l <= csb;
    end
end

// Hold the CPU until the ROM data is in
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        rom_cs_l <= 1'b0;
        wait_n   <= 1'b1;
    end else begin
        rom_cs_l <= rom_cs;
        if (rom_cs && !rom_cs_l)
            wait_n <= 1'b0;
        else if (rom_ok)
            wait_n <= 1'b1;
    end
end

endmodule

// ==== design/main_ram.sv ====
`timescale 1ns/1ps

module main_ram
    import bus_pkg::*;
(
    input  logic      clk,
    input  logic      cpu_cen,
    input  logic      ram_cs,
    input  logic      wr_n,
    input  cpu_addr_t ad,
    input  byte_t     cpu_dout,
    input  logic      dma_cs,
    input  dma_addr_t ad_dma,
    output byte_t     ram_q
);

byte_t     mem [2**$bits(ram_addr_t)];
ram_addr_t ram_addr;
byte_t     ram_din;
logic      ram_we;
logic      last_wr_n;

// Falling wr_n marks the CPU write
always_ff @(posedge clk) begin
    last_wr_n <= wr_n;
    if (dma_cs)
        ram_addr <= {1'b1, ad_dma};   // DMA reads the sprite half
    else if (ram_cs)
        ram_addr <= ad[$bits(ram_addr_t)-1:0];
    if (ram_cs && !wr_n && last_wr_n) begin
        ram_we  <= 1'b1;
        ram_din <= cpu_dout;
    end else if (cpu_cen) begin
        ram_we <= 1'b0;
    end
end

// Array port runs at CPU speed
always_ff @(posedge clk) begin
    if (cpu_cen) begin
        if (ram_we)
            mem[ram_addr] <= ram_din;
        ram_q <= mem[ram_addr];
    end
end

endmodule

// ==== design/security_chip.sv ====
`timescale 1ns/1ps

module security_chip
    import bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  cpu_cen,
    input  logic  sec_cs,
    input  logic  rd_n,
    input  logic  wr_n,
    input  logic  a0,
    input  byte_t din,
    output byte_t dout
);

logic [15:0] shreg;
logic [15:0] shifted;
logic [2:0]  shamt;
logic        last_wr_n;

// Each write acts once, however long the CPU holds it
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        shreg     <= 16'd0;
        shamt     <= 3'd0;
        last_wr_n <= 1'b1;
    end else if (cpu_cen) begin
        last_wr_n <= wr_n;
        if (sec_cs && !wr_n && last_wr_n) begin
            if (a0)
                shamt <= din[2:0];
            else
                shreg <= {din, shreg[15:8]};   // New byte enters at the top
        end
    end
end

assign shifted = shreg << shamt;

always_comb begin
    dout = 8'h00;
    if (sec_cs && !rd_n)
        dout = a0 ? {5'd0, shamt} : shifted[15:8];
end

endmodule

// ==== design/nmi_watchdog.sv ====
`timescale 1ns/1ps

`include "popeye_defs.svh"

module nmi_watchdog
    import bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cpu_cen,
    input  logic      mreq_n,
    input  logic      rfsh_n,
    input  cpu_addr_t ad,
    input  logic      vb,
    output logic      nmi_n,
    output logic      cpu_rst_n
);

localparam int WD_CW = $clog2(`POPEYE_WD_LIMIT);

logic             rfsh_mreq;
logic             rfsh_l;
logic             rfsh_rise;
logic             vb_l;
logic             vb_rise;
logic             nmi_en;
logic             cpu_ok;
logic [WD_CW-1:0] wd_cnt;
logic             wd_rst;
logic [1:0]       rst_sync;

assign rfsh_mreq = ~rfsh_n & ~mreq_n;
assign rfsh_rise = rfsh_mreq & ~rfsh_l;
assign vb_rise   = vb & ~vb_l;

//////////////////////////////
// Refresh latches and NMI
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        rfsh_l <= 1'b0;
        vb_l   <= 1'b0;
        nmi_en <= 1'b0;
        cpu_ok <= 1'b1;
        nmi_n  <= 1'b1;
    end else if (cpu_cen) begin
        rfsh_l <= rfsh_mreq;
        vb_l   <= vb;
        if (rfsh_rise) begin
            nmi_en <= ad[9];
            cpu_ok <= ad[5];
        end
        if (!nmi_en)
            nmi_n <= 1'b1;        // Disabled, NMI released
        else if (vb_rise)
            nmi_n <= 1'b0;
    end
end

//////////////////////////////
// Watchdog
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        wd_cnt <= '0;
        wd_rst <= 1'b0;
    end else if (nmi_en || cpu_ok) begin
        wd_cnt <= '0;
        wd_rst <= 1'b0;
    end else if (cpu_cen && vb_rise && !wd_rst) begin
        wd_cnt <= wd_cnt + 1'b1;
        if (wd_cnt == WD_CW'(`POPEYE_WD_LIMIT - 1))
            wd_rst <= 1'b1;       // Sticks until the game kicks it
    end
end

// Two flops down to the CPU reset pin
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
        rst_sync <= 2'b11;
    else
        rst_sync <= {rst_sync[0], ~wd_rst};
end

assign cpu_rst_n = rst_sync[1];

endmodule

// ==== design/popeye_main.sv ====
`timescale 1ns/1ps

module popeye_main
    import bus_pkg::*;
    import board_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cpu_cen,
    input  logic       encrypted,
    // CPU bus
    input  logic       mreq_n,
    input  logic       iorq_n,
    input  logic       rd_n,
    input  logic       wr_n,
    input  logic       rfsh_n,
    input  cpu_addr_t  cpu_addr,     // As it leaves the CPU
    input  byte_t      cpu_dout,
    output byte_t      cpu_din,
    output cpu_addr_t  ad,
    output logic       wait_n,
    output logic       nmi_n,
    output logic       cpu_rst_n,
    // ROM
    output logic       rom_cs,
    output rom_addr_t  rom_addr,
    input  byte_t      rom_data,
    input  logic       rom_ok,
    // Sprite DMA
    input  logic       dma_cs,
    input  dma_addr_t  ad_dma,
    output byte_t      dd_dma,
    // Video
    input  logic       vb,
    output logic       mem_wr,
    output logic       csv_l,
    output logic       csb_w_n,
    output logic       dwrbk,
    // Cabinet
    input  logic       coin,
    input  logic       service,
    input  logic       initeo,
    input  logic [1:0] start,
    input  joy_t       joy1,
    input  joy_t       joy2,
    input  dip1_t      dip1
);

byte_t rom_good;
byte_t sec_q;
logic  ram_cs;
logic  sec_cs;

addr_unscramble u_unscramble (
    .encrypted (encrypted),
    .cpu_addr  (cpu_addr),
    .rom_data  (rom_data),
    .ad        (ad),
    .rom_addr  (rom_addr),
    .rom_good  (rom_good)
);

bus_decode u_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .cpu_cen  (cpu_cen),
    .mreq_n   (mreq_n),
    .iorq_n   (iorq_n),
    .rd_n     (rd_n),
    .wr_n     (wr_n),
    .ad       (ad),
    .rom_good (rom_good),
    .ram_q    (dd_dma),       // RAM output doubles as DMA data
    .sec_q    (sec_q),
    .rom_ok   (rom_ok),
    .coin     (coin),
    .service  (service),
    .initeo   (initeo),
    .start    (start),
    .joy1     (joy1),
    .joy2     (joy2),
    .dip1     (dip1),
    .rom_cs   (rom_cs),
    .ram_cs   (ram_cs),
    .sec_cs   (sec_cs),
    .wait_n   (wait_n),
    .mem_wr   (mem_wr),
    .csv_l    (csv_l),
    .csb_w_n  (csb_w_n),
    .dwrbk    (dwrbk),
    .cpu_din  (cpu_din)
);

main_ram u_ram (
    .clk      (clk),
    .cpu_cen  (cpu_cen),
    .ram_cs   (ram_cs),
    .wr_n     (wr_n),
    .ad       (ad),
    .cpu_dout (cpu_dout),
    .dma_cs   (dma_cs),
    .ad_dma   (ad_dma),
    .ram_q    (dd_dma)
);

security_chip u_security (
    .clk     (clk),
    .rst_n   (rst_n),
    .cpu_cen (cpu_cen),
    .sec_cs  (sec_cs),
    .rd_n    (rd_n),
    .wr_n    (wr_n),
    .a0      (ad[0]),
    .din     (cpu_dout),
    .dout    (sec_q)
);

nmi_watchdog u_nmi_wd (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpu_cen   (cpu_cen),
    .mreq_n    (mreq_n),
    .rfsh_n    (rfsh_n),
    .ad        (ad),
    .vb        (vb),
    .nmi_n     (nmi_n),
    .cpu_rst_n (cpu_rst_n)
);

endmodule

// ==== verification/popeye_clkgen.sv ====
`timescale 1ns/1ps

module popeye_clkgen (
    output logic clk
);

initial clk = 1'b0;

always #2 clk = ~clk;   // 4 ns period

endmodule

// ==== verification/popeye_main_assert.sv ====
`timescale 1ns/1ps

module popeye_main_assert (
    input logic clk,
    input logic rst_n,
    input logic rom_cs,
    input logic ram_cs,
    input logic sec_cs,
    input logic wait_n,
    input logic rom_ok,
    input logic nmi_n,
    input logic nmi_en
);

// One device per memory cycle
selects_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({rom_cs, ram_cs, sec_cs}))
    else $error("More than one chip select high");

wait_release: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(wait_n) |-> $past(rom_ok))
    else $error("wait_n released without rom_ok");

// Enable clear long enough for the latch to follow
nmi_blocked: assert property (@(posedge clk) disable iff (!rst_n)
    (!nmi_en && !$past(nmi_en) && !$past(nmi_en, 2)) |-> nmi_n)
    else $error("nmi_n low while NMI disabled");

endmodule

bind popeye_main popeye_main_assert u_assert (
    .clk    (clk),
    .rst_n  (rst_n),
    .rom_cs (rom_cs),
    .ram_cs (ram_cs),
    .sec_cs (sec_cs),
    .wait_n (wait_n),
    .rom_ok (rom_ok),
    .nmi_n  (nmi_n),
    .nmi_en (u_nmi_wd.nmi_en)
);

// ==== verification/popeye_main_tb.sv ====
`timescale 1ns/1ps

module popeye_main_tb
    import bus_pkg::*;
    import board_pkg::*;
();

logic clk, rst_n, cpu_cen, encrypted;
logic mreq_n, iorq_n, rd_n, wr_n, rfsh_n;
cpu_addr_t cpu_addr, ad;
byte_t cpu_dout, cpu_din, rom_data, dd_dma;
logic wait_n, nmi_n, cpu_rst_n, rom_cs, rom_ok, dma_cs, vb;
rom_addr_t rom_addr;
dma_addr_t ad_dma;
logic mem_wr, csv_l, csb_w_n, dwrbk, coin, service, initeo;
logic [1:0] start;
joy_t joy1, joy2;
dip1_t dip1;
logic [31:0] lfsr = 32'ha5050596;
logic saw_wait_low, saw_mem_wr, saw_csv, rom_armed;
logic saw_rom_cs, saw_dwrbk, saw_csb_w;
cpu_addr_t cycle_ad;
int rom_wait;

popeye_clkgen u_clkgen (.clk(clk));

popeye_main popeye_main_inst (.*);

function automatic logic lfsr_step();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
        v = {v[30:0], lfsr_step()};
    return v;
endfunction

// Fill depends on every address bit
function automatic byte_t rom_fill(input rom_addr_t a);
    return a[7:0] ^ {1'b0, a[14:8]} ^ 8'h3c;
endfunction

//////////////////////////////
// ROM model, answers after 1 to 7 clocks
always @(posedge clk) begin
    rom_data <= rom_fill(rom_addr);
    if (!rom_cs) begin
        rom_ok    <= 1'b0;
        rom_armed <= 1'b0;
    end else if (!rom_armed) begin
        rom_wait  <= 1 + int'(rand_bits(3)) % 7;
        rom_armed <= 1'b1;
    end else if (rom_wait > 1) begin
        rom_wait <= rom_wait - 1;
    end else begin
        rom_ok <= 1'b1;
    end
end

always @(posedge clk) cpu_cen <= ~cpu_cen;

task automatic stop_fail(input string why);
    $display("%s at %0t", why, $time);
    $display("*** FAILED ***");
    $fatal(1);
endtask

task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
        $display("Fail %0t %s got %02h expected %02h", $time, name, got, exp);
        $display("*** FAILED ***");
        $fatal(1);
    end
endtask

task automatic check_addr(input string name, input cpu_addr_t got, input cpu_addr_t exp);
    if (got !== exp) begin
        $display("Fail %0t %s got %04h expected %04h", $time, name, got, exp);
        $display("*** FAILED ***");
        $fatal(1);
    end
endtask

task automatic check_rom_addr(input string name, input rom_addr_t got, input rom_addr_t exp);
    if (got !== exp) begin
        $display("Fail %0t %s got %04h expected %04h", $time, name, got, exp);
        $display("*** FAILED ***");
        $fatal(1);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
        $display("*** FAILED ***");
        $fatal(1);
    end
endtask

//////////////////////////////
// CPU bus cycles
task automatic bus_cycle(input logic mreq, iorq, rd, wr, rfsh,
                         input cpu_addr_t a, input byte_t d);
    int n;
    @(posedge clk);
    mreq_n   <= mreq;
    iorq_n   <= iorq;
    rd_n     <= rd;
    wr_n     <= wr;
    rfsh_n   <= rfsh;
    cpu_addr <= a;
    cpu_dout <= d;
    n = 0;
    saw_wait_low = 1'b0;
    saw_mem_wr = 1'b0;
    saw_csv = 1'b0;
    saw_rom_cs = 1'b0;
    saw_dwrbk = 1'b0;
    saw_csb_w = 1'b0;
    do begin        // At least 8 clocks, longer if wait_n holds us
        @(negedge clk);
        n++;
        if (!wait_n) saw_wait_low = 1'b1;
        if (mem_wr) saw_mem_wr = 1'b1;
        if (csv_l) saw_csv = 1'b1;
        if (rom_cs) saw_rom_cs = 1'b1;
        if (dwrbk) saw_dwrbk = 1'b1;
        if (!csb_w_n) saw_csb_w = 1'b1;
        if (n > 64) stop_fail("Bus cycle timed out with wait_n low");
    end while (n < 8 || !wait_n);
    cycle_ad = ad;
endtask

task automatic bus_idle();
    @(posedge clk);
    {mreq_n, iorq_n, rd_n, wr_n, rfsh_n} <= 5'b11111;
    repeat (3) @(posedge clk);
endtask

task automatic mem_read(input cpu_addr_t a, output byte_t q, output rom_addr_t ra);
    bus_cycle(1'b0, 1'b1, 1'b0, 1'b1, 1'b1, a, 8'h00);
    q = cpu_din;
    ra = rom_addr;
    bus_idle();
endtask

task automatic mem_write(input cpu_addr_t a, input byte_t d);
    bus_cycle(1'b0, 1'b1, 1'b1, 1'b0, 1'b1, a, d);
    bus_idle();
endtask

task automatic io_read(input cpu_addr_t a, output byte_t q);
    bus_cycle(1'b1, 1'b0, 1'b0, 1'b1, 1'b1, a, 8'h00);
    q = cpu_din;
    bus_idle();
endtask

task automatic refresh(input cpu_addr_t a);
    bus_cycle(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, a, 8'h00);
    bus_idle();
endtask

task automatic pulse_vb();
    @(posedge clk);
    vb <= 1'b1;
    repeat (4) @(posedge clk);
    vb <= 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
endtask

task automatic dma_read(input dma_addr_t a, output byte_t q);
    @(posedge clk);
    dma_cs <= 1'b1;
    ad_dma <= a;
    repeat (8) @(negedge clk);
    q = dd_dma;
    @(posedge clk);
    dma_cs <= 1'b0;
endtask

//////////////////////////////
// Directed tests
task automatic test_rom_fetch();
    cpu_addr_t a, pa;
    byte_t q, d;
    rom_addr_t ra;
    mem_read(16'h1234, q, ra);
    check_rom_addr("rom_addr", ra, 15'h1234);
    check_addr("ad", cycle_ad, 16'h1234);
    check_byte("cpu_din", q, rom_fill(15'h1234));
    check_bit("rom_cs_seen", saw_rom_cs, 1'b1);
    check_bit("wait_n_low_seen", saw_wait_low, 1'b1);
    mem_read(16'h8400, q, ra);          // Below the RAM window, still ROM
    check_rom_addr("rom_addr", ra, 15'h0400);
    check_byte("cpu_din", q, rom_fill(15'h0400));
    check_bit("rom_cs_seen", saw_rom_cs, 1'b1);
    check_bit("wait_n_low_seen", saw_wait_low, 1'b1);
    @(posedge clk) encrypted <= 1'b1;
    for (int i = 0; i < 4; i++) begin
        a = {1'b0, 15'(rand_bits(15))};
        pa = {a[15:10], a[8], a[7], a[6], a[3], ~a[9], ~a[5], ~a[4], ~a[2:0]};
        mem_read(a, q, ra);
        d = rom_fill(pa[14:0]);
        check_rom_addr("rom_addr", ra, pa[14:0]);
        check_addr("ad", cycle_ad, pa);
        check_byte("cpu_din", q, {d[3], d[4], d[2], d[5], d[1], d[6], d[0], d[7]});
        check_bit("wait_n_low_seen", saw_wait_low, 1'b1);
    end
    @(posedge clk) encrypted <= 1'b0;
endtask

task automatic test_ram();
    cpu_addr_t a [8];
    byte_t d [8];
    byte_t q;
    rom_addr_t ra;
    for (int i = 0; i < 8; i++) begin
        a[i] = 16'h8800 | cpu_addr_t'(i << 8) | cpu_addr_t'(rand_bits(8));
        d[i] = byte_t'(rand_bits(8));
        mem_write(a[i], d[i]);
        check_bit("mem_wr_seen", saw_mem_wr, 1'b1);
    end
    for (int i = 0; i < 8; i++) begin
        mem_read(a[i], q, ra);
        check_byte("cpu_din", q, d[i]);
        check_bit("rom_cs_seen", saw_rom_cs, 1'b0);
    end
    for (int i = 4; i < 8; i++) begin     // Upper half, sprite area
        dma_read(a[i][9:0], q);
        check_byte("dd_dma", q, d[i]);
    end
endtask

task automatic test_security();
    byte_t b0, b1, q;
    logic [2:0] amt;
    logic [15:0] sh;
    rom_addr_t ra;
    for (int i = 0; i < 3; i++) begin
        amt = 3'(rand_bits(3));
        b0 = byte_t'(rand_bits(8));
        b1 = byte_t'(rand_bits(8));
        mem_write(16'he001, {5'd0, amt});
        mem_write(16'he000, b0);
        mem_write(16'he000, b1);
        sh = {b1, b0} << amt;
        mem_read(16'he000, q, ra);
        check_byte("sec_data", q, sh[15:8]);
        mem_read(16'he001, q, ra);
        check_byte("sec_shift", q, {5'd0, amt});
    end
endtask

task automatic test_cabinet();
    byte_t q;
    rom_addr_t ra;
    @(posedge clk);
    dip1 <= dip1_t'(rand_bits(4));
    joy1 <= joy_t'(rand_bits(5));
    joy2 <= joy_t'(rand_bits(5));
    {coin, service, initeo} <= 3'(rand_bits(3));
    start <= 2'(rand_bits(2));
    io_read(16'h0000, q);
    check_byte("port0", q, {4'hf, dip1});
    io_read(16'h0001, q);
    check_byte("port1", q, {coin, service, initeo, 1'b1, start, 2'b11});
    io_read(16'h0002, q);
    check_byte("port2", q, {3'b111, joy2});
    io_read(16'h0003, q);
    check_byte("port3", q, {3'b111, joy1});
    mem_read(16'ha000, q, ra);
    check_byte("cpu_din", q, 8'hff);
    check_bit("csv_l_seen", saw_csv, 1'b1);
    check_bit("rom_cs_seen", saw_rom_cs, 1'b0);
    check_bit("csb_w_n_low_seen", saw_csb_w, 1'b0);
endtask

task automatic test_bkg_strobes();
    byte_t q;
    rom_addr_t ra;
    mem_read(16'hc000, q, ra);          // Plane selected, no write strobe
    check_byte("cpu_din", q, 8'hff);
    check_bit("csb_w_n_low_seen", saw_csb_w, 1'b1);
    check_bit("dwrbk_seen", saw_dwrbk, 1'b0);
    mem_write(16'hd001, 8'h5a);
    check_bit("dwrbk_seen", saw_dwrbk, 1'b1);
    check_bit("csb_w_n_low_seen", saw_csb_w, 1'b1);
    check_bit("mem_wr_seen", saw_mem_wr, 1'b1);
endtask

task automatic test_nmi();
    int n;
    pulse_vb();
    check_bit("nmi_n", nmi_n, 1'b1);
    refresh(16'h0220);                  // Enable on, cpu_ok kept
    pulse_vb();
    n = 0;
    while (nmi_n) begin
        @(negedge clk);
        n++;
        if (n > 32) stop_fail("nmi_n never fell after vertical blank");
    end
    refresh(16'h0020);
    n = 0;
    while (!nmi_n) begin
        @(negedge clk);
        n++;
        if (n > 32) stop_fail("nmi_n stayed low after the enable was cleared");
    end
endtask

task automatic test_watchdog();
    int n;
    refresh(16'h0000);
    for (int i = 0; i < 15; i++) begin
        pulse_vb();
        check_bit("cpu_rst_n", cpu_rst_n, 1'b1);
    end
    pulse_vb();
    n = 0;
    while (cpu_rst_n) begin
        @(negedge clk);
        n++;
        if (n > 32) stop_fail("Watchdog never reset the CPU");
    end
    refresh(16'h0020);
    n = 0;
    while (!cpu_rst_n) begin
        @(negedge clk);
        n++;
        if (n > 32) stop_fail("CPU reset not released by the refresh");
    end
endtask

initial begin
    rst_n = 1'b0;
    cpu_cen = 1'b0;
    encrypted = 1'b0;
    {mreq_n, iorq_n, rd_n, wr_n, rfsh_n} = 5'b11111;
    cpu_addr = '0;
    cpu_dout = '0;
    rom_data = '0;
    rom_ok = 1'b0;
    rom_armed = 1'b0;
    rom_wait = 0;
    dma_cs = 1'b0;
    ad_dma = '0;
    vb = 1'b0;
    {coin, service, initeo} = 3'b111;
    start = 2'b11;
    joy1 = '1;
    joy2 = '1;
    dip1 = '1;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    test_rom_fetch();
    test_ram();
    test_security();
    test_cabinet();
    test_bkg_strobes();
    test_nmi();
    test_watchdog();
    $display("*** PASSED ***");
    $finish;
end

endmodule

// ==== sim.f ====
+incdir+design
design/bus_pkg.sv
design/board_pkg.sv
design/addr_unscramble.sv
design/bus_decode.sv
design/main_ram.sv
design/security_chip.sv
design/nmi_watchdog.sv
design/popeye_main.sv
verification/popeye_clkgen.sv
verification/popeye_main_assert.sv
verification/popeye_main_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the popeye_main testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module popeye_main_tb -o popeye_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/popeye_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
